//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = csi2_framer_tb
FILELIST  = csi2_framer.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

# the run passes only when the pass line shows up in its output
sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(OBJ_DIR)

//--- csi2_framer.f
design/csi2_pkg.sv
design/csi2_byte_if.sv
design/raw10_packer.sv
design/line_fifo.sv
design/csi2_crc16.sv
design/csi2_pkt_ctrl.sv
design/csi2_framer.sv
verification/csi2_framer_tb.sv

//--- design/csi2_byte_if.sv
// valid/ready byte stream with a last flag, shared between framer blocks
`timescale 1ns/1ns
`default_nettype none

interface csi2_byte_if;

    logic [7:0] data;
    logic       valid;
    logic       ready;
    // marks final byte of a line or packet
    logic       last;

    // producer side
    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    // consumer side
    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

//--- design/csi2_crc16.sv
// CSI-2 long packet payload CRC-16, cleared per packet and fed one byte per cycle
`timescale 1ns/1ns
`default_nettype none

module csi2_crc16 (
    input  wire logic        byte_clk,
    input  wire logic        reset_n_byte,
    input  wire logic        clear_i,
    input  wire logic        enable_i,
    input  wire logic [7:0]  data_i,
    output logic      [15:0] crc_o
);

    logic [15:0] crc_q;

    // reflected poly 0x8408, bits taken lsb first
    function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] d);
        logic [15:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ d[i];
            c  = c >> 1;
            if (fb) begin
                c = c ^ 16'h8408;
            end
        end
        return c;
    endfunction

    always_ff @(posedge byte_clk or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            crc_q <= 16'hFFFF;
        end else if (clear_i) begin
            crc_q <= 16'hFFFF;
        end else if (enable_i) begin
            crc_q <= crc_byte(crc_q, data_i);
        end
    end

    // no final inversion
    assign crc_o = crc_q;

endmodule

`default_nettype wire

//--- design/csi2_framer.sv
// CSI-2 RAW10 framer top, pixels and frame events in, packet byte stream out
`timescale 1ns/1ns
`default_nettype none

module csi2_framer #(
    parameter int LINE_PIXELS = 16,
    parameter int FIFO_DEPTH  = 32
) (
    input  wire logic       byte_clk,
    input  wire logic       reset_n_byte,
    input  wire logic [1:0] vc_i,
    input  wire logic       fs_i,
    input  wire logic       fe_i,
    input  wire logic [9:0] pix_data_i,
    input  wire logic       pix_valid_i,
    input  wire logic       pix_last_i,
    output logic            pix_ready_o,
    output logic      [7:0] tx_data_o,
    output logic            tx_valid_o,
    output logic            tx_last_o,
    input  wire logic       tx_ready_i
);

    // packer to line buffer
    csi2_byte_if pix_bytes ();
    // line buffer to packet controller
    csi2_byte_if line_bytes ();

    logic        packer_idle;
    logic        lines_ready;
    logic        fifo_empty;
    logic        crc_clear;
    logic        crc_enable;
    logic [7:0]  crc_data;
    logic [15:0] crc;

    raw10_packer i_raw10_packer (
        .byte_clk     (byte_clk),
        .reset_n_byte (reset_n_byte),
        .pix_data_i   (pix_data_i),
        .pix_valid_i  (pix_valid_i),
        .pix_last_i   (pix_last_i),
        .pix_ready_o  (pix_ready_o),
        .out          (pix_bytes.source),
        .idle_o       (packer_idle)
    );

    line_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_line_fifo (
        .byte_clk      (byte_clk),
        .reset_n_byte  (reset_n_byte),
        .wr            (pix_bytes.sink),
        .rd            (line_bytes.source),
        .lines_ready_o (lines_ready),
        .empty_o       (fifo_empty)
    );

    csi2_crc16 i_csi2_crc16 (
        .byte_clk     (byte_clk),
        .reset_n_byte (reset_n_byte),
        .clear_i      (crc_clear),
        .enable_i     (crc_enable),
        .data_i       (crc_data),
        .crc_o        (crc)
    );

    csi2_pkt_ctrl #(
        .LINE_PIXELS (LINE_PIXELS)
    ) i_csi2_pkt_ctrl (
        .byte_clk      (byte_clk),
        .reset_n_byte  (reset_n_byte),
        .vc_i          (vc_i),
        .fs_i          (fs_i),
        .fe_i          (fe_i),
        .payload       (line_bytes.sink),
        .lines_ready_i (lines_ready),
        .fifo_empty_i  (fifo_empty),
        .packer_idle_i (packer_idle),
        .crc_clear_o   (crc_clear),
        .crc_enable_o  (crc_enable),
        .crc_data_o    (crc_data),
        .crc_i         (crc),
        .tx_data_o     (tx_data_o),
        .tx_valid_o    (tx_valid_o),
        .tx_last_o     (tx_last_o),
        .tx_ready_i    (tx_ready_i)
    );

endmodule

`default_nettype wire

//--- design/csi2_pkg.sv
// shared CSI-2 types and header ECC function, imported by the packet controller
`default_nettype none

package csi2_pkg;

    // data identifier types this framer emits
    typedef enum logic [5:0] {
        DT_FRAME_START = 6'h00,
        DT_FRAME_END   = 6'h01,
        DT_RAW10       = 6'h2B
    } csi2_dt_e;

    // packet controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD,
        ST_CRC
    } ctrl_state_e;

    // 6-bit hamming parity over the 24-bit packet header
    // hdr[7:0] data id, hdr[15:8] wc low, hdr[23:16] wc high
    // each mask lists the header bits covered by one parity bit
    function automatic logic [7:0] csi2_header_ecc(input logic [23:0] hdr);
        logic [5:0] p;
        // p0 covers d0-2,4,5,7,10,11,13,16,20-23
        p[0] = ^(hdr & 24'hF12CB7);
        // p1 covers d0,1,3,4,6,8,10,12,14,17,20-23
        p[1] = ^(hdr & 24'hF2555B);
        // p2 covers d0,2,3,5,6,9,11,12,15,18,20-22
        p[2] = ^(hdr & 24'h749A6D);
        // p3 covers d1-3,7-9,13-15,19-21,23
        p[3] = ^(hdr & 24'hB8E38E);
        // p4 covers d4-9,16-20,22,23
        p[4] = ^(hdr & 24'hDF03F0);
        // p5 covers d10-19,21-23
        p[5] = ^(hdr & 24'hEFFC00);
        // top two bits are reserved
        return {2'b00, p};
    endfunction

endpackage

`default_nettype wire

//--- design/csi2_pkt_ctrl.sv
// CSI-2 packet sequencer, builds short and long packet headers and streams payload and CRC
`timescale 1ns/1ns
`default_nettype none

module csi2_pkt_ctrl #(
    parameter int LINE_PIXELS = 16
) (
    input  wire logic        byte_clk,
    input  wire logic        reset_n_byte,
    input  wire logic [1:0]  vc_i,
    input  wire logic        fs_i,
    input  wire logic        fe_i,
    csi2_byte_if.sink        payload,
    input  wire logic        lines_ready_i,
    input  wire logic        fifo_empty_i,
    input  wire logic        packer_idle_i,
    output logic             crc_clear_o,
    output logic             crc_enable_o,
    output logic      [7:0]  crc_data_o,
    input  wire logic [15:0] crc_i,
    output logic      [7:0]  tx_data_o,
    output logic             tx_valid_o,
    output logic             tx_last_o,
    input  wire logic        tx_ready_i
);

    import csi2_pkg::*;

    // RAW10 bytes per line
    localparam logic [15:0] WORD_COUNT = 16'(LINE_PIXELS * 10 / 8);

    ctrl_state_e state;
    logic        fs_pend;
    logic        fe_pend;
    logic [15:0] frame_num;
    // header or crc byte index
    logic [1:0]  byte_idx;
    logic [15:0] pay_cnt;

    // header fields latched at packet launch
    csi2_dt_e    hdr_dt;
    logic [1:0]  hdr_vc;
    logic [15:0] hdr_word;
    logic [7:0]  hdr_di;
    logic [7:0]  hdr_ecc;

    logic launch_fs;
    logic launch_line;
    logic launch_fe;
    logic hdr_xfer;
    logic pay_xfer;
    logic crc_xfer;

    // ordering, frame start then lines then frame end once drained
    assign launch_fs   = fs_pend;
    assign launch_line = !fs_pend && lines_ready_i;
    assign launch_fe   = !fs_pend && !lines_ready_i && fe_pend && fifo_empty_i && packer_idle_i;

    assign hdr_xfer = (state == ST_HEADER) && tx_ready_i;
    assign pay_xfer = (state == ST_PAYLOAD) && payload.valid && tx_ready_i;
    assign crc_xfer = (state == ST_CRC) && tx_ready_i;

    always_ff @(posedge byte_clk or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            state     <= ST_IDLE;
            fs_pend   <= 1'b0;
            fe_pend   <= 1'b0;
            frame_num <= 16'd1;
            byte_idx  <= 2'd0;
            pay_cnt   <= 16'd0;
        end else begin
            // new events win over a clear in the same cycle
            fs_pend <= fs_i || (fs_pend && !(hdr_xfer && byte_idx == 2'd0 &&
                                            hdr_dt == DT_FRAME_START));
            fe_pend <= fe_i || (fe_pend && !(hdr_xfer && byte_idx == 2'd0 &&
                                            hdr_dt == DT_FRAME_END));
            case (state)
                ST_IDLE: begin
                    byte_idx <= 2'd0;
                    if (launch_fs || launch_line || launch_fe) begin
                        state <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (hdr_xfer) begin
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == 2'd3) begin
                            pay_cnt <= 16'd0;
                            // short packets end at the ecc byte
                            state   <= (hdr_dt == DT_RAW10) ? ST_PAYLOAD : ST_IDLE;
                            // frame end closes the frame
                            if (hdr_dt == DT_FRAME_END) begin
                                frame_num <= frame_num + 16'd1;
                            end
                        end
                    end
                end
                ST_PAYLOAD: begin
                    if (pay_xfer) begin
                        pay_cnt <= pay_cnt + 16'd1;
                        if (pay_cnt == WORD_COUNT - 16'd1) begin
                            byte_idx <= 2'd0;
                            state    <= ST_CRC;
                        end
                    end
                end
                default: begin
                    if (crc_xfer) begin
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == 2'd1) begin
                            state <= ST_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // header fields, only read outside idle
    always_ff @(posedge byte_clk) begin
        if (state == ST_IDLE) begin
            hdr_vc <= vc_i;
            if (launch_fs) begin
                hdr_dt   <= DT_FRAME_START;
                hdr_word <= frame_num;
            end else if (launch_line) begin
                hdr_dt   <= DT_RAW10;
                hdr_word <= WORD_COUNT;
            end else begin
                hdr_dt   <= DT_FRAME_END;
                hdr_word <= frame_num;
            end
        end
    end

    assign hdr_di  = {hdr_vc, hdr_dt};
    assign hdr_ecc = csi2_header_ecc({hdr_word, hdr_di});

    // output mux, every source is held while tx is stalled
    always_comb begin
        case (state)
            ST_HEADER: begin
                case (byte_idx)
                    2'd0:    tx_data_o = hdr_di;
                    2'd1:    tx_data_o = hdr_word[7:0];
                    2'd2:    tx_data_o = hdr_word[15:8];
                    default: tx_data_o = hdr_ecc;
                endcase
            end
            ST_PAYLOAD: tx_data_o = payload.data;
            // crc low byte first
            ST_CRC:     tx_data_o = byte_idx[0] ? crc_i[15:8] : crc_i[7:0];
            default:    tx_data_o = 8'h00;
        endcase
    end

    assign tx_valid_o = (state == ST_HEADER) || (state == ST_CRC) ||
                        ((state == ST_PAYLOAD) && payload.valid);
    assign tx_last_o  = ((state == ST_HEADER) && byte_idx == 2'd3 && hdr_dt != DT_RAW10) ||
                        ((state == ST_CRC) && byte_idx == 2'd1);

    // payload passes straight through under tx back-pressure
    assign payload.ready = (state == ST_PAYLOAD) && tx_ready_i;

    // crc restarts as each line is launched
    assign crc_clear_o  = (state == ST_IDLE) && launch_line;
    assign crc_enable_o = pay_xfer;
    assign crc_data_o   = payload.data;

    // packer line end must land exactly on the word count
    a_line_length: assert property (@(posedge byte_clk) disable iff (!reset_n_byte)
        pay_xfer |-> (payload.last == (pay_cnt == WORD_COUNT - 16'd1)));

endmodule

`default_nettype wire

//--- design/line_fifo.sv
// byte FIFO between packer and packet controller that counts the whole lines it holds
`timescale 1ns/1ns
`default_nettype none

module line_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  wire logic   byte_clk,
    input  wire logic   reset_n_byte,
    csi2_byte_if.sink   wr,
    csi2_byte_if.source rd,
    output logic        lines_ready_o,
    output logic        empty_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    // entry is {last, data}
    logic [8:0]  mem [FIFO_DEPTH];
    // extra msb tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    // complete lines held
    logic [AW:0] line_cnt;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;
    logic wr_eol;
    logic rd_eol;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign wr.ready = !full;
    assign wr_en    = wr.valid && wr.ready;
    assign rd_en    = rd.valid && rd.ready;
    assign wr_eol   = wr_en && wr.last;
    assign rd_eol   = rd_en && rd.last;

    // head entry shows up the cycle after its write
    assign rd.valid = !empty;
    assign rd.data  = mem[rd_ptr[AW-1:0]][7:0];
    assign rd.last  = mem[rd_ptr[AW-1:0]][8];

    always_ff @(posedge byte_clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= {wr.last, wr.data};
        end
    end

    always_ff @(posedge byte_clk or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            line_cnt <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // line end in and out together leaves count alone
            if (wr_eol && !rd_eol) begin
                line_cnt <= line_cnt + 1'b1;
            end else if (rd_eol && !wr_eol) begin
                line_cnt <= line_cnt - 1'b1;
            end
        end
    end

    assign lines_ready_o = (line_cnt != '0);
    assign empty_o       = empty;

    // a full buffer always holds a whole line for the controller to drain
    a_full_holds_line: assert property (@(posedge byte_clk) disable iff (!reset_n_byte)
        full |-> (line_cnt != '0));

    // a line end leaving the buffer was counted on entry
    a_line_cnt_underflow: assert property (@(posedge byte_clk) disable iff (!reset_n_byte)
        rd_eol |-> (line_cnt != '0));

endmodule

`default_nettype wire

//--- design/raw10_packer.sv
// packs groups of four 10-bit pixels into five RAW10 bytes for the line buffer
`timescale 1ns/1ns
`default_nettype none

module raw10_packer (
    input  wire logic        byte_clk,
    input  wire logic        reset_n_byte,
    input  wire logic [9:0]  pix_data_i,
    input  wire logic        pix_valid_i,
    input  wire logic        pix_last_i,
    output logic             pix_ready_o,
    csi2_byte_if.source      out,
    output logic             idle_o
);

    // pixels of the current group
    logic [9:0] pix_q [4];
    // pixels collected so far
    logic [1:0] pix_cnt;
    // group complete, bytes being offered
    logic       sending;
    // byte being offered, 0 to 4
    logic [2:0] byte_idx;
    // group closes a line
    logic       group_last;

    logic pix_xfer;
    logic byte_xfer;

    // no pixels taken while the group is being emitted
    assign pix_ready_o = !sending;
    assign pix_xfer    = pix_valid_i && pix_ready_o;
    assign byte_xfer   = out.valid && out.ready;

    always_ff @(posedge byte_clk or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            pix_cnt    <= 2'd0;
            sending    <= 1'b0;
            byte_idx   <= 3'd0;
            group_last <= 1'b0;
        end else begin
            if (pix_xfer) begin
                pix_cnt <= pix_cnt + 2'd1;
                // fourth pixel starts the byte sequence
                if (pix_cnt == 2'd3) begin
                    sending    <= 1'b1;
                    byte_idx   <= 3'd0;
                    group_last <= pix_last_i;
                end
            end
            if (byte_xfer) begin
                if (byte_idx == 3'd4) begin
                    sending <= 1'b0;
                end else begin
                    byte_idx <= byte_idx + 3'd1;
                end
            end
        end
    end

    // pixel store
    always_ff @(posedge byte_clk) begin
        if (pix_xfer) begin
            pix_q[pix_cnt] <= pix_data_i;
        end
    end

    // bytes 0-3 carry msbs, byte 4 packs the lsb pairs
    always_comb begin
        if (byte_idx == 3'd4) begin
            out.data = {pix_q[3][1:0], pix_q[2][1:0], pix_q[1][1:0], pix_q[0][1:0]};
        end else begin
            out.data = pix_q[byte_idx[1:0]][9:2];
        end
    end

    assign out.valid = sending;
    assign out.last  = group_last && (byte_idx == 3'd4);

    // nothing collected and nothing left to send
    assign idle_o = (pix_cnt == 2'd0) && !sending;

    // line length must be a whole number of groups
    a_last_on_fourth: assert property (@(posedge byte_clk) disable iff (!reset_n_byte)
        (pix_xfer && pix_last_i) |-> (pix_cnt == 2'd3));

endmodule

`default_nettype wire

//--- verification/csi2_framer_tb.sv
// directed testbench for the CSI-2 framer, run as top module through the Verilator Makefile
`timescale 1ns/1ns
`default_nettype none

module csi2_framer_tb;

    localparam int          LINE_PIXELS    = 16;
    localparam logic [15:0] WORD_COUNT     = 16'(LINE_PIXELS * 10 / 8);
    // ~6 frames of ~100 bytes at 50% ready, with wide margin
    localparam int          TIMEOUT_CYCLES = 20000;
    localparam logic [31:0] SEED           = 32'hc5f2_ab87;

    // syndrome column per header bit, from the CSI-2 ECC table
    localparam logic [5:0] ECC_COL [24] = '{
        6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
        6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
        6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
    };

    logic       byte_clk;
    logic       reset_n_byte;
    logic [1:0] vc_i;
    logic       fs_i;
    logic       fe_i;
    logic [9:0] pix_data_i;
    logic       pix_valid_i;
    logic       pix_last_i;
    logic       pix_ready_o;
    logic [7:0] tx_data_o;
    logic       tx_valid_o;
    logic       tx_last_o;
    logic       tx_ready_i = 1'b1;

    // received and expected bytes, {last, data}
    logic [8:0]  rx_q [$];
    logic [8:0]  exp_q [$];
    logic [9:0]  line_pix [LINE_PIXELS];
    logic [31:0] pix_rng = SEED;
    logic [31:0] ready_rng = SEED;
    logic        bp_en = 1'b0;
    logic [15:0] frame_num = 16'd1;
    int          cycles = 0;

    // stall tracking for the hold check
    logic       stalled = 1'b0;
    logic [7:0] held_data;
    logic       held_last;

    csi2_framer i_csi2_framer (
        .byte_clk     (byte_clk),
        .reset_n_byte (reset_n_byte),
        .vc_i         (vc_i),
        .fs_i         (fs_i),
        .fe_i         (fe_i),
        .pix_data_i   (pix_data_i),
        .pix_valid_i  (pix_valid_i),
        .pix_last_i   (pix_last_i),
        .pix_ready_o  (pix_ready_o),
        .tx_data_o    (tx_data_o),
        .tx_valid_o   (tx_valid_o),
        .tx_last_o    (tx_last_o),
        .tx_ready_i   (tx_ready_i)
    );

    initial begin
        byte_clk = 1'b0;
        forever #10 byte_clk = ~byte_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // xor of the columns of every set header bit
    function automatic logic [7:0] ecc_of_header(input logic [23:0] hdr);
        logic [5:0] syn;
        syn = 6'd0;
        for (int i = 0; i < 24; i++) begin
            if (hdr[i]) begin
                syn = syn ^ ECC_COL[i];
            end
        end
        return {2'b00, syn};
    endfunction

    // one payload byte into the running crc, lsb first
    function automatic logic [15:0] crc16_fold(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c  = {1'b0, c[15:1]} ^ (fb ? 16'h8408 : 16'h0000);
        end
        return c;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // tx ready pattern, random under back-pressure
    always @(negedge byte_clk) begin
        if (bp_en) begin
            ready_rng  = xorshift32(ready_rng);
            tx_ready_i <= ready_rng[0];
        end else begin
            tx_ready_i <= 1'b1;
        end
    end

    // collector, also checks that a stalled byte stays put
    always @(posedge byte_clk) begin
        if (stalled) begin
            compare_value("tx_valid_o", 32'(1'b1), 32'(tx_valid_o));
            compare_value("tx_data_o", 32'(held_data), 32'(tx_data_o));
            compare_value("tx_last_o", 32'(held_last), 32'(tx_last_o));
        end
        if (tx_valid_o && tx_ready_i) begin
            rx_q.push_back({tx_last_o, tx_data_o});
        end
        stalled   = tx_valid_o && !tx_ready_i;
        held_data = tx_data_o;
        held_last = tx_last_o;
    end

    // watchdog
    always @(posedge byte_clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "run timed out");
        end
    end

    // frame start or frame end, four bytes
    task automatic push_short_packet(input logic [5:0] dt, input logic [15:0] fn);
        logic [23:0] hdr;
        hdr = {fn, vc_i, dt};
        exp_q.push_back({1'b0, hdr[7:0]});
        exp_q.push_back({1'b0, hdr[15:8]});
        exp_q.push_back({1'b0, hdr[23:16]});
        exp_q.push_back({1'b1, ecc_of_header(hdr)});
    endtask

    // long packet for the pixels in line_pix
    task automatic push_line_packet();
        logic [23:0] hdr;
        logic [7:0]  b;
        logic [15:0] crc;
        hdr = {WORD_COUNT, vc_i, 6'h2B};
        exp_q.push_back({1'b0, hdr[7:0]});
        exp_q.push_back({1'b0, hdr[15:8]});
        exp_q.push_back({1'b0, hdr[23:16]});
        exp_q.push_back({1'b0, ecc_of_header(hdr)});
        crc = 16'hFFFF;
        for (int g = 0; g < LINE_PIXELS / 4; g++) begin
            for (int k = 0; k < 5; k++) begin
                // four msb bytes, then the packed lsb pairs
                if (k < 4) begin
                    b = line_pix[4 * g + k][9:2];
                end else begin
                    b = {line_pix[4 * g + 3][1:0], line_pix[4 * g + 2][1:0],
                         line_pix[4 * g + 1][1:0], line_pix[4 * g][1:0]};
                end
                crc = crc16_fold(crc, b);
                exp_q.push_back({1'b0, b});
            end
        end
        exp_q.push_back({1'b0, crc[7:0]});
        exp_q.push_back({1'b1, crc[15:8]});
    endtask

    task automatic new_line_pixels();
        for (int i = 0; i < LINE_PIXELS; i++) begin
            pix_rng     = xorshift32(pix_rng);
            line_pix[i] = pix_rng[9:0];
        end
    endtask

    // pixel handshake, fe_i pulsed with pixel fe_at when it is not negative
    task automatic send_pixels(input int fe_at);
        for (int i = 0; i < LINE_PIXELS; i++) begin
            pix_data_i  = line_pix[i];
            pix_valid_i = 1'b1;
            pix_last_i  = (i == LINE_PIXELS - 1);
            if (i == fe_at) begin
                fe_i = 1'b1;
            end
            // ready only moves on the rising edge
            while (!pix_ready_o) begin
                @(negedge byte_clk);
                fe_i = 1'b0;
            end
            @(negedge byte_clk);
            fe_i = 1'b0;
        end
        pix_valid_i = 1'b0;
        pix_last_i  = 1'b0;
    endtask

    task automatic pulse_event(input logic is_start);
        @(negedge byte_clk);
        if (is_start) begin
            fs_i = 1'b1;
        end else begin
            fe_i = 1'b1;
        end
        @(negedge byte_clk);
        fs_i = 1'b0;
        fe_i = 1'b0;
    endtask

    // waits for every expected byte, then compares in order
    task automatic match_received();
        logic [8:0] want;
        logic [8:0] got;
        while (rx_q.size() < exp_q.size()) begin
            @(negedge byte_clk);
        end
        while (exp_q.size() > 0) begin
            want = exp_q.pop_front();
            got  = rx_q.pop_front();
            compare_value("tx_data_o", 32'(want[7:0]), 32'(got[7:0]));
            compare_value("tx_last_o", 32'(want[8]), 32'(got[8]));
        end
    endtask

    task automatic reset_values();
        @(negedge byte_clk);
        compare_value("tx_valid_o", 32'(1'b0), 32'(tx_valid_o));
        compare_value("pix_ready_o", 32'(1'b1), 32'(pix_ready_o));
    endtask

    task automatic frame_start_packet();
        @(negedge byte_clk);
        vc_i = 2'd1;
        pulse_event(1'b1);
        push_short_packet(6'h00, frame_num);
        match_received();
    endtask

    task automatic single_line();
        @(negedge byte_clk);
        new_line_pixels();
        push_line_packet();
        send_pixels(-1);
        match_received();
    endtask

    task automatic line_under_backpressure();
        @(posedge byte_clk);
        bp_en = 1'b1;
        @(negedge byte_clk);
        new_line_pixels();
        push_line_packet();
        send_pixels(-1);
        match_received();
        @(posedge byte_clk);
        bp_en = 1'b0;
    endtask

    // frame end keeps the frame number, next frame start moves on
    task automatic frame_end_and_count();
        pulse_event(1'b0);
        push_short_packet(6'h01, frame_num);
        match_received();
        frame_num = frame_num + 16'd1;
        pulse_event(1'b1);
        push_short_packet(6'h00, frame_num);
        match_received();
    endtask

    // fe_i arrives mid-line, the line goes out first
    task automatic frame_end_ordering();
        @(negedge byte_clk);
        new_line_pixels();
        push_line_packet();
        push_short_packet(6'h01, frame_num);
        send_pixels(9);
        match_received();
        frame_num = frame_num + 16'd1;
    endtask

    initial begin
        reset_n_byte = 1'b0;
        vc_i         = 2'd0;
        fs_i         = 1'b0;
        fe_i         = 1'b0;
        pix_data_i   = 10'd0;
        pix_valid_i  = 1'b0;
        pix_last_i   = 1'b0;
        repeat (8) @(posedge byte_clk);
        @(negedge byte_clk);
        reset_n_byte = 1'b1;

        reset_values();
        frame_start_packet();
        single_line();
        line_under_backpressure();
        frame_end_and_count();
        frame_end_ordering();

        // nothing extra may follow
        repeat (20) @(negedge byte_clk);
        compare_value("extra output bytes", 32'd0, 32'(rx_q.size()));
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
